/* design/conv_defs.svh */
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// ****************************************
// Engine sizes
// ****************************************
`define CONV_UNITS      4
`define KERNEL_W_MAX    3
`define DATA_WIDTH      16
`define ACC_WIDTH       40
`define FRAC_BITS       8
`define TUSER_WIDTH     8

// ****************************************
// Pipeline depths
// ****************************************
`define MUL_DELAY       2
`define CONV_LATENCY    (`KERNEL_W_MAX - 1 + `MUL_DELAY + 2)

// Configuration port.
`define CFG_ADDR_WIDTH  2
`define CFG_DATA_WIDTH  8

`endif

/* design/conv_types_pkg.sv */
`default_nettype none

`include "conv_defs.svh"

package conv_types_pkg;

    // Pixels and weights share one signed fixed-point format.
    typedef logic signed [`DATA_WIDTH-1:0] data_t;

    typedef logic signed [2*`DATA_WIDTH-1:0] prod_t; // Full product of two data_t values.

    // Wide enough to sum many products before the output shift.
    typedef logic signed [`ACC_WIDTH-1:0] acc_t;

    typedef logic [`TUSER_WIDTH-1:0] user_t;

    // Holds 1 to KERNEL_W_MAX.
    typedef logic [$clog2(`KERNEL_W_MAX + 1)-1:0] taps_t;

endpackage

`default_nettype wire

/* design/conv_cfg_pkg.sv */
`default_nettype none

`include "conv_defs.svh"

package conv_cfg_pkg;

    typedef enum logic [`CFG_ADDR_WIDTH-1:0] {
        CFG_KERNEL = 0,  // Bits 1:0 hold kernel width minus one.
        CFG_MODE   = 1,  // Bit 0 selects 1x1, bit 1 enables ReLU.
        CFG_CTRL   = 2   // Writing bit 0 starts a new run.
    } cfg_addr_e;

    // A unit is in ACC_RUN while a group of beats is open.
    typedef enum logic {
        ACC_IDLE,
        ACC_RUN
    } acc_state_e;

endpackage

`default_nettype wire

/* design/conv_cfg_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "conv_defs.svh"

module conv_cfg_regs (
    input  wire                         aclk,
    input  wire                         arst_n,
    input  wire                         cfg_wr,
    input  wire [`CFG_ADDR_WIDTH-1:0]   cfg_addr,
    input  wire [`CFG_DATA_WIDTH-1:0]   cfg_wdata,
    output logic [`CFG_DATA_WIDTH-1:0]  cfg_rdata,
    output conv_types_pkg::taps_t       tap_count,
    output logic                        relu,
    output logic                        start
);

    logic [1:0] kernel_w_1;
    logic       is_1x1;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            kernel_w_1 <= 2'd2;
            is_1x1     <= 1'b0;
            relu       <= 1'b0;
            start      <= 1'b0;
        end else begin
            start <= cfg_wr && (cfg_addr == conv_cfg_pkg::CFG_CTRL) && cfg_wdata[0];
            if (cfg_wr && (cfg_addr == conv_cfg_pkg::CFG_KERNEL)) begin
                kernel_w_1 <= cfg_wdata[1:0];
            end
            if (cfg_wr && (cfg_addr == conv_cfg_pkg::CFG_MODE)) begin
                is_1x1 <= cfg_wdata[0];
                relu   <= cfg_wdata[1];
            end
        end
    end

    // ****************************************
    // Readback and derived tap count
    // ****************************************
    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            conv_cfg_pkg::CFG_KERNEL: cfg_rdata[1:0] = kernel_w_1;
            conv_cfg_pkg::CFG_MODE:   cfg_rdata[1:0] = {relu, is_1x1};
            default:                  cfg_rdata = '0; // CTRL is write only.
        endcase
    end

    always_comb begin
        if (is_1x1) begin
            tap_count = conv_types_pkg::taps_t'(1);
        end else if (kernel_w_1 >= (`KERNEL_W_MAX - 1)) begin
            tap_count = conv_types_pkg::taps_t'(`KERNEL_W_MAX); // Wider kernels are clamped.
        end else begin
            tap_count = conv_types_pkg::taps_t'(kernel_w_1 + 2'd1);
        end
    end

endmodule

`default_nettype wire

/* design/step_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module step_buffer #(
    parameter int LANES      = 3,
    parameter int LANE_WIDTH = 16
) (
    input  wire                         aclk,
    input  wire                         aclken,
    input  wire                         arst_n,
    input  wire                         s_valid,
    input  wire [LANES*LANE_WIDTH-1:0]  s_data,
    output wire [LANES-1:0]             m_valid,
    output wire [LANES*LANE_WIDTH-1:0]  m_data
);

    for (genvar k = 0; k < LANES; k++) begin : g_lane
        if (k == 0) begin : g_direct
            assign m_valid[0]              = s_valid; // Lane 0 is not delayed.
            assign m_data[0 +: LANE_WIDTH] = s_data[0 +: LANE_WIDTH];
        end else begin : g_delay
            logic [k-1:0]          vld_q;
            logic [LANE_WIDTH-1:0] data_q [k];

            always_ff @(posedge aclk or negedge arst_n) begin
                if (!arst_n) begin
                    vld_q <= '0;
                end else if (aclken) begin
                    vld_q[0] <= s_valid;
                    for (int i = 1; i < k; i++) vld_q[i] <= vld_q[i-1];
                end
            end

            always_ff @(posedge aclk) begin
                if (aclken) begin
                    data_q[0] <= s_data[k*LANE_WIDTH +: LANE_WIDTH];
                    for (int i = 1; i < k; i++) data_q[i] <= data_q[i-1];
                end
            end

            assign m_valid[k]                         = vld_q[k-1];
            assign m_data[k*LANE_WIDTH +: LANE_WIDTH] = data_q[k-1];
        end
    end

endmodule

`default_nettype wire

/* design/conv_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "conv_defs.svh"

module conv_unit (
    input  wire                                 aclk,
    input  wire                                 aclken,
    input  wire                                 arst_n,
    input  wire                                 start,
    input  wire conv_types_pkg::taps_t          tap_count,
    input  wire                                 relu,
    input  wire [`KERNEL_W_MAX-1:0]             s_valid,
    input  wire [`KERNEL_W_MAX*`DATA_WIDTH-1:0] s_pixels,
    input  wire [`KERNEL_W_MAX*`DATA_WIDTH-1:0] s_weights,
    input  wire                                 s_last,
    input  wire conv_types_pkg::user_t          s_user,
    output wire                                 m_valid,
    output conv_types_pkg::data_t               m_data,
    output wire                                 m_last,
    output conv_types_pkg::user_t               m_user
);

    localparam int TAPS      = `KERNEL_W_MAX;
    localparam int MD        = `MUL_DELAY;
    localparam int TAG_DELAY = `CONV_LATENCY - 2; // Lane 0 entry to the chain end.
    localparam int OUT_MAX   = 2 ** (`DATA_WIDTH - 1) - 1;
    localparam int OUT_MIN   = -(2 ** (`DATA_WIDTH - 1));

    conv_types_pkg::data_t      pix      [TAPS];
    conv_types_pkg::data_t      wgt      [TAPS];
    conv_types_pkg::prod_t      prod_in  [TAPS];
    conv_types_pkg::prod_t      prod_q   [TAPS][MD];
    conv_types_pkg::acc_t       chain_q  [TAPS-1];
    conv_types_pkg::acc_t       psum     [TAPS];
    conv_types_pkg::acc_t       acc_q;
    conv_types_pkg::acc_t       acc_base;
    conv_types_pkg::user_t      user_q   [TAG_DELAY];
    conv_types_pkg::user_t      acc_user_q;
    conv_cfg_pkg::acc_state_e   state_q;
    logic [MD-1:0]              end_vld_q;
    logic [TAG_DELAY-1:0]       last_q;
    logic                       end_vld;
    logic                       end_last;
    logic                       done_q;
    logic                       out_vld_q;

    function automatic conv_types_pkg::data_t scale_out(input conv_types_pkg::acc_t value,
                                                        input logic rectify);
        conv_types_pkg::acc_t  shifted;
        conv_types_pkg::data_t result;
        shifted = value >>> `FRAC_BITS;
        if (shifted > conv_types_pkg::acc_t'(OUT_MAX)) begin
            result = conv_types_pkg::data_t'(OUT_MAX);
        end else if (shifted < conv_types_pkg::acc_t'(OUT_MIN)) begin
            result = conv_types_pkg::data_t'(OUT_MIN);
        end else begin
            result = conv_types_pkg::data_t'(shifted);
        end
        if (rectify && (result < 0)) result = '0;
        return result;
    endfunction

    // ****************************************
    // Multipliers, one per staggered tap
    // ****************************************
    always_comb begin
        for (int k = 0; k < TAPS; k++) begin
            pix[k] = s_pixels[k*`DATA_WIDTH +: `DATA_WIDTH];
            wgt[k] = s_weights[k*`DATA_WIDTH +: `DATA_WIDTH];
            if (s_valid[k] && (k < tap_count)) begin
                prod_in[k] = pix[k] * wgt[k];
            end else begin
                prod_in[k] = '0; // Idle or inactive taps add nothing.
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (aclken) begin
            for (int k = 0; k < TAPS; k++) begin
                prod_q[k][0] <= prod_in[k];
                for (int d = 1; d < MD; d++) prod_q[k][d] <= prod_q[k][d-1];
            end
        end
    end

    // Systolic adder chain. Tap k's product meets the partial sum one cycle after tap k-1's.
    always_comb begin
        psum[0] = prod_q[0][MD-1];
        for (int k = 1; k < TAPS; k++) psum[k] = chain_q[k-1] + prod_q[k][MD-1];
    end

    always_ff @(posedge aclk) begin
        if (aclken) begin
            for (int k = 0; k < TAPS - 1; k++) chain_q[k] <= psum[k];
        end
    end

    // Tags travel from lane 0, valid from the last lane.
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            end_vld_q <= '0;
            last_q    <= '0;
        end else if (aclken) begin
            end_vld_q[0] <= s_valid[TAPS-1];
            for (int d = 1; d < MD; d++) end_vld_q[d] <= end_vld_q[d-1];
            last_q[0] <= s_last;
            for (int d = 1; d < TAG_DELAY; d++) last_q[d] <= last_q[d-1];
        end
    end

    always_ff @(posedge aclk) begin
        if (aclken) begin
            user_q[0] <= s_user;
            for (int d = 1; d < TAG_DELAY; d++) user_q[d] <= user_q[d-1];
        end
    end

    assign end_vld  = end_vld_q[MD-1];
    assign end_last = last_q[TAG_DELAY-1];

    // ****************************************
    // Beat accumulator
    // ****************************************
    always_comb begin
        acc_base = (state_q == conv_cfg_pkg::ACC_RUN) ? acc_q : '0;
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= conv_cfg_pkg::ACC_IDLE;
            done_q  <= 1'b0;
        end else begin
            if (aclken) begin
                done_q <= end_vld && end_last;
                if (end_vld) begin
                    state_q <= end_last ? conv_cfg_pkg::ACC_IDLE : conv_cfg_pkg::ACC_RUN;
                end
            end
            if (start) state_q <= conv_cfg_pkg::ACC_IDLE;
        end
    end

    always_ff @(posedge aclk) begin
        if (start) begin
            acc_q <= '0;
        end else if (aclken && end_vld) begin
            acc_q <= acc_base + psum[TAPS-1];
        end
        if (aclken && end_vld) acc_user_q <= user_q[TAG_DELAY-1];
    end

    // Output stage. Each result closes a group, so last follows valid.
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            out_vld_q <= 1'b0;
        end else if (aclken) begin
            out_vld_q <= done_q;
        end
    end

    always_ff @(posedge aclk) begin
        if (aclken) begin
            m_data <= scale_out(acc_q, relu);
            m_user <= acc_user_q;
        end
    end

    assign m_valid = out_vld_q && aclken;  // A frozen cycle shows no pulse.
    assign m_last  = out_vld_q && aclken;

endmodule

`default_nettype wire

/* design/conv_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "conv_defs.svh"

module conv_core (
    input  wire                                              aclk,
    input  wire                                              aclken,
    input  wire                                              arst_n,
    input  wire                                              start,
    input  wire conv_types_pkg::taps_t                       tap_count,
    input  wire                                              relu,
    input  wire                                              s_valid,
    input  wire [`KERNEL_W_MAX*`DATA_WIDTH-1:0]              s_weights_data,
    input  wire [`CONV_UNITS*`KERNEL_W_MAX*`DATA_WIDTH-1:0]  s_pixels_data,
    input  wire                                              s_last,
    input  wire conv_types_pkg::user_t                       s_user,
    output wire                                              s_ready,
    output wire                                              m_valid,
    output wire [`CONV_UNITS*`DATA_WIDTH-1:0]                m_data,
    output wire                                              m_last,
    output wire conv_types_pkg::user_t                       m_user
);

    localparam int UNITS = `CONV_UNITS;
    localparam int TAPS  = `KERNEL_W_MAX;
    localparam int DW    = `DATA_WIDTH;

    wire [TAPS*UNITS*DW-1:0]    pix_by_lane;
    wire [TAPS*UNITS*DW-1:0]    pix_step;
    wire [TAPS-1:0]             pix_step_valid;
    wire [TAPS*DW-1:0]          wgt_step;
    wire [TAPS-1:0]             wgt_step_valid;
    wire [TAPS-1:0]             step_valid;

    wire                        unit_valid [UNITS];
    wire                        unit_last  [UNITS];
    wire conv_types_pkg::user_t unit_user  [UNITS];
    wire conv_types_pkg::data_t unit_data  [UNITS];

    assign s_ready = aclken; // The pipeline only stalls when the clock enable drops.

    // Input pixels are grouped by unit. The step buffer wants them grouped by tap.
    for (genvar u = 0; u < UNITS; u++) begin : g_regroup
        for (genvar k = 0; k < TAPS; k++) begin : g_tap
            assign pix_by_lane[(k*UNITS+u)*DW +: DW] = s_pixels_data[(u*TAPS+k)*DW +: DW];
        end
    end

    // ****************************************
    // Staggering of weights and pixels
    // ****************************************
    step_buffer #(
        .LANES      (TAPS),
        .LANE_WIDTH (DW)
    ) step_weights (
        .aclk    (aclk),
        .aclken  (aclken),
        .arst_n  (arst_n),
        .s_valid (s_valid),
        .s_data  (s_weights_data),
        .m_valid (wgt_step_valid),
        .m_data  (wgt_step)
    );

    step_buffer #(
        .LANES      (TAPS),
        .LANE_WIDTH (UNITS*DW)
    ) step_pixels (
        .aclk    (aclk),
        .aclken  (aclken),
        .arst_n  (arst_n),
        .s_valid (s_valid),
        .s_data  (pix_by_lane),
        .m_valid (pix_step_valid),
        .m_data  (pix_step)
    );

    assign step_valid = pix_step_valid & wgt_step_valid;

    for (genvar u = 0; u < UNITS; u++) begin : g_unit
        wire [TAPS*DW-1:0] unit_pix;

        for (genvar k = 0; k < TAPS; k++) begin : g_tap
            assign unit_pix[k*DW +: DW] = pix_step[(k*UNITS+u)*DW +: DW];
        end

        conv_unit unit (
            .aclk      (aclk),
            .aclken    (aclken),
            .arst_n    (arst_n),
            .start     (start),
            .tap_count (tap_count),
            .relu      (relu),
            .s_valid   (step_valid),
            .s_pixels  (unit_pix),
            .s_weights (wgt_step),
            .s_last    (s_last),
            .s_user    (s_user),
            .m_valid   (unit_valid[u]),
            .m_data    (unit_data[u]),
            .m_last    (unit_last[u]),
            .m_user    (unit_user[u])
        );

        assign m_data[u*DW +: DW] = unit_data[u];
    end

    // All units run in lockstep, so unit 0 speaks for the stream tags.
    assign m_valid = unit_valid[0];
    assign m_last  = unit_last[0];
    assign m_user  = unit_user[0];

endmodule

`default_nettype wire

/* design/conv_engine.sv */
`timescale 1ns/10ps
`default_nettype none

`include "conv_defs.svh"

module conv_engine (
    input  wire                                              aclk,
    input  wire                                              aclken,
    input  wire                                              arst_n,
    input  wire                                              cfg_wr,
    input  wire [`CFG_ADDR_WIDTH-1:0]                        cfg_addr,
    input  wire [`CFG_DATA_WIDTH-1:0]                        cfg_wdata,
    output wire [`CFG_DATA_WIDTH-1:0]                        cfg_rdata,
    input  wire                                              s_valid,
    input  wire [`KERNEL_W_MAX*`DATA_WIDTH-1:0]              s_weights_data,
    input  wire [`CONV_UNITS*`KERNEL_W_MAX*`DATA_WIDTH-1:0]  s_pixels_data,
    input  wire                                              s_last,
    input  wire [`TUSER_WIDTH-1:0]                           s_user,
    output wire                                              s_ready,
    output wire                                              m_valid,
    output wire [`CONV_UNITS*`DATA_WIDTH-1:0]                m_data,
    output wire                                              m_last,
    output wire [`TUSER_WIDTH-1:0]                           m_user
);

    wire conv_types_pkg::taps_t tap_count;
    wire                        relu;
    wire                        start;

    conv_cfg_regs regs (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .tap_count (tap_count),
        .relu      (relu),
        .start     (start)
    );

    conv_core core (
        .aclk           (aclk),
        .aclken         (aclken),
        .arst_n         (arst_n),
        .start          (start),
        .tap_count      (tap_count),
        .relu           (relu),
        .s_valid        (s_valid),
        .s_weights_data (s_weights_data),
        .s_pixels_data  (s_pixels_data),
        .s_last         (s_last),
        .s_user         (s_user),
        .s_ready        (s_ready),
        .m_valid        (m_valid),
        .m_data         (m_data),
        .m_last         (m_last),
        .m_user         (m_user)
    );

endmodule

`default_nettype wire

/* bench/conv_engine_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "conv_defs.svh"

module conv_engine_tb;

    localparam int     UNITS          = `CONV_UNITS;
    localparam int     TAPS           = `KERNEL_W_MAX;
    localparam int     DW             = `DATA_WIDTH;
    localparam int     TIMEOUT_CYCLES = 2000;  // All tests take a few hundred cycles.
    localparam longint OUT_HI         = 2 ** (DW - 1) - 1;
    localparam longint OUT_LO         = -(2 ** (DW - 1));

    logic                         aclk;
    logic                         aclken;
    logic                         arst_n;
    logic                         cfg_wr;
    logic [`CFG_ADDR_WIDTH-1:0]   cfg_addr;
    logic [`CFG_DATA_WIDTH-1:0]   cfg_wdata;
    wire  [`CFG_DATA_WIDTH-1:0]   cfg_rdata;
    logic                         s_valid;
    logic [TAPS*DW-1:0]           s_weights_data;
    logic [UNITS*TAPS*DW-1:0]     s_pixels_data;
    logic                         s_last;
    logic [`TUSER_WIDTH-1:0]      s_user;
    wire                          s_ready;
    wire                          m_valid;
    wire  [UNITS*DW-1:0]          m_data;
    wire                          m_last;
    wire  [`TUSER_WIDTH-1:0]      m_user;

    // Reference model state, owned by the monitor.
    conv_types_pkg::acc_t         model_acc [UNITS];
    logic [1:0]                   model_kernel_w_1;
    logic                         model_is_1x1;
    logic                         model_relu;
    logic [UNITS*DW-1:0]          exp_data_q [$];
    conv_types_pkg::user_t        exp_user_q [$];
    longint                       exp_due_q  [$];
    longint                       en_count;
    int                           out_count;
    int                           cycle_count = 0;

    // Stimulus state, owned by the main sequence.
    int                           groups_sent;
    logic                         hold_mode;

    conv_engine uut (
        .aclk           (aclk),
        .aclken         (aclken),
        .arst_n         (arst_n),
        .cfg_wr         (cfg_wr),
        .cfg_addr       (cfg_addr),
        .cfg_wdata      (cfg_wdata),
        .cfg_rdata      (cfg_rdata),
        .s_valid        (s_valid),
        .s_weights_data (s_weights_data),
        .s_pixels_data  (s_pixels_data),
        .s_last         (s_last),
        .s_user         (s_user),
        .s_ready        (s_ready),
        .m_valid        (m_valid),
        .m_data         (m_data),
        .m_last         (m_last),
        .m_user         (m_user)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_now($sformatf("Timeout: the run did not finish within %0d cycles", cycle_count));
        end
    end

    // ****************************************
    // Reference model
    // ****************************************
    function automatic int active_taps();
        if (model_is_1x1) return 1;
        if (int'(model_kernel_w_1) + 1 > TAPS) return TAPS;
        return int'(model_kernel_w_1) + 1;
    endfunction

    function automatic conv_types_pkg::data_t expected_output(input conv_types_pkg::acc_t sum,
                                                              input logic rectify);
        longint value;
        value = longint'(sum) >>> `FRAC_BITS;  // Arithmetic shift keeps the sign.
        if (value > OUT_HI) begin
            value = OUT_HI;
        end else if (value < OUT_LO) begin
            value = OUT_LO;
        end
        if (rectify && (value < 0)) value = 0;
        return conv_types_pkg::data_t'(value);
    endfunction

    function automatic void absorb_beat();
        conv_types_pkg::data_t pix;
        conv_types_pkg::data_t wgt;
        logic [UNITS*DW-1:0]   expected;
        for (int u = 0; u < UNITS; u++) begin
            for (int k = 0; k < active_taps(); k++) begin
                pix = conv_types_pkg::data_t'(s_pixels_data[(u*TAPS+k)*DW +: DW]);
                wgt = conv_types_pkg::data_t'(s_weights_data[k*DW +: DW]);
                model_acc[u] = model_acc[u]
                             + conv_types_pkg::acc_t'(pix) * conv_types_pkg::acc_t'(wgt);
            end
            expected[u*DW +: DW] = expected_output(model_acc[u], model_relu);
        end
        if (s_last) begin
            exp_data_q.push_back(expected);
            exp_user_q.push_back(s_user);
            exp_due_q.push_back(en_count + `CONV_LATENCY);
            for (int u = 0; u < UNITS; u++) model_acc[u] = '0;
        end
    endfunction

    function automatic void track_write();
        case (cfg_addr)
            conv_cfg_pkg::CFG_KERNEL: model_kernel_w_1 = cfg_wdata[1:0];
            conv_cfg_pkg::CFG_MODE: begin
                model_is_1x1 = cfg_wdata[0];
                model_relu   = cfg_wdata[1];
            end
            conv_cfg_pkg::CFG_CTRL: begin
                if (cfg_wdata[0]) begin
                    for (int u = 0; u < UNITS; u++) model_acc[u] = '0;  // Start drops partial sums.
                end
            end
            default: ;
        endcase
    endfunction

    task automatic compare_output();
        logic [UNITS*DW-1:0]   want;
        conv_types_pkg::user_t want_user;
        want      = exp_data_q.pop_front();
        want_user = exp_user_q.pop_front();
        void'(exp_due_q.pop_front());
        for (int u = 0; u < UNITS; u++) begin
            assert (m_data[u*DW +: DW] == want[u*DW +: DW]) else
                fail_now($sformatf("FAIL m_data unit %0d: got %h expected %h",
                                   u, m_data[u*DW +: DW], want[u*DW +: DW]));
        end
        assert (m_last) else fail_now($sformatf("FAIL m_last: got %h expected 1", m_last));
        assert (m_user == want_user) else
            fail_now($sformatf("FAIL m_user: got %h expected %h", m_user, want_user));
    endtask

    // ****************************************
    // Monitor
    // ****************************************
    always @(posedge aclk) begin : monitor
        logic due_now;
        if (!arst_n) begin
            model_kernel_w_1 = 2'd2;
            model_is_1x1     = 1'b0;
            model_relu       = 1'b0;
            en_count         = 0;
            out_count        = 0;
            for (int u = 0; u < UNITS; u++) model_acc[u] = '0;
        end else begin
            due_now = aclken && (exp_due_q.size() != 0) && (exp_due_q[0] == en_count);
            if (!aclken) begin
                assert (!m_valid) else
                    fail_now($sformatf("FAIL m_valid: got %h expected 0 while aclken is low",
                                       m_valid));
            end else begin
                assert (m_valid == due_now) else
                    fail_now($sformatf("FAIL m_valid: got %h expected %h", m_valid, due_now));
            end
            assert (s_ready == aclken) else
                fail_now($sformatf("FAIL s_ready: got %h expected %h", s_ready, aclken));
            if (m_valid) out_count = out_count + 1;
            if (due_now) compare_output();
            if (s_valid && s_ready) absorb_beat();
            if (cfg_wr) track_write();
            if (aclken) en_count = en_count + 1;  // Latency is counted in enabled cycles.
        end
    end

    // ****************************************
    // Stimulus helpers
    // ****************************************
    function automatic logic [DW-1:0] rand_word(input int lo, input int hi);
        int value;
        value = lo + int'($urandom_range(unsigned'(hi - lo)));
        return value[DW-1:0];
    endfunction

    function automatic logic pick_enable();
        if (!hold_mode) return 1'b1;
        return ($urandom_range(3) != 0);
    endfunction

    task automatic write_reg(input conv_cfg_pkg::cfg_addr_e addr, input logic [7:0] data);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge aclk);
        cfg_wr    = 1'b0;
        cfg_wdata = '0;
    endtask

    task automatic check_reg(input conv_cfg_pkg::cfg_addr_e addr, input logic [7:0] want);
        cfg_addr = addr;
        @(negedge aclk);
        assert (cfg_rdata == want) else
            fail_now($sformatf("FAIL cfg_rdata at %h: got %h expected %h", addr, cfg_rdata, want));
    endtask

    // Mode 0 is small mixed data, 1 and 2 saturate high and low, 3 gives negative sums.
    task automatic fill_beat(input int mode);
        int plo;
        int phi;
        int wlo;
        int whi;
        plo = -1024;
        phi = 1023;
        wlo = -1024;
        whi = 1023;
        if (mode == 1 || mode == 2) begin
            plo = 16000;
            phi = 32767;
            wlo = (mode == 1) ? 16000 : -32768;
            whi = (mode == 1) ? 32767 : -16000;
        end else if (mode == 3) begin
            plo = 1;
            wlo = -1023;
            whi = -1;
        end
        for (int k = 0; k < TAPS; k++) s_weights_data[k*DW +: DW] = rand_word(wlo, whi);
        for (int i = 0; i < UNITS * TAPS; i++) s_pixels_data[i*DW +: DW] = rand_word(plo, phi);
    endtask

    task automatic send_beat(input int mode, input logic last, input logic [7:0] user);
        fill_beat(mode);
        s_valid = 1'b1;
        s_last  = last;
        s_user  = user;
        do begin
            aclken = pick_enable();
            @(negedge aclk);
        end while (!aclken);
    endtask

    task automatic send_group(input int beats, input int mode);
        logic [7:0] user;
        for (int i = 0; i < beats; i++) begin
            user = 8'($urandom_range(255));
            send_beat(mode, i == beats - 1, user);
        end
        groups_sent = groups_sent + 1;
    endtask

    task automatic end_stream();
        s_valid = 1'b0;
        s_last  = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_due_q.size() != 0) begin
            aclken = pick_enable();
            @(negedge aclk);
        end
        aclken = 1'b1;
        assert (out_count == groups_sent) else
            fail_now($sformatf("FAIL out_count: got %h expected %h", out_count, groups_sent));
    endtask

    // ****************************************
    // Directed tests
    // ****************************************
    task automatic test_registers();
        check_reg(conv_cfg_pkg::CFG_KERNEL, 8'h02);
        check_reg(conv_cfg_pkg::CFG_MODE, 8'h00);
        check_reg(conv_cfg_pkg::CFG_CTRL, 8'h00);
        for (int w = 0; w < 4; w++) begin
            write_reg(conv_cfg_pkg::CFG_KERNEL, 8'(w));
            check_reg(conv_cfg_pkg::CFG_KERNEL, 8'(w));
        end
        write_reg(conv_cfg_pkg::CFG_KERNEL, 8'hfd);  // Only bits 1:0 are stored.
        check_reg(conv_cfg_pkg::CFG_KERNEL, 8'h01);
        write_reg(conv_cfg_pkg::CFG_MODE, 8'h03);
        check_reg(conv_cfg_pkg::CFG_MODE, 8'h03);
        write_reg(conv_cfg_pkg::CFG_MODE, 8'h00);
        check_reg(conv_cfg_pkg::CFG_MODE, 8'h00);
        write_reg(conv_cfg_pkg::CFG_KERNEL, 8'h02);
    endtask

    task automatic test_single_beat();
        send_group(1, 0);
        end_stream();
        wait_drain();
    endtask

    task automatic test_accumulate_saturate();
        for (int g = 0; g < 9; g++) send_group(1 + int'($urandom_range(4)), g % 3);
        end_stream();
        wait_drain();
    endtask

    task automatic test_taps_relu();
        for (int cfg = 0; cfg < 3; cfg++) begin
            write_reg(conv_cfg_pkg::CFG_KERNEL, (cfg == 2) ? 8'h02 : 8'(cfg));
            write_reg(conv_cfg_pkg::CFG_MODE, (cfg == 2) ? 8'h01 : 8'h00);
            send_group(2, 0);
            send_group(3, 0);
            end_stream();
            wait_drain();
        end
        write_reg(conv_cfg_pkg::CFG_KERNEL, 8'h02);
        write_reg(conv_cfg_pkg::CFG_MODE, 8'h02);
        send_group(2, 3);
        send_group(1, 0);
        send_group(3, 3);
        end_stream();
        wait_drain();
        write_reg(conv_cfg_pkg::CFG_MODE, 8'h00);
    endtask

    task automatic test_enable_hold();
        hold_mode = 1'b1;
        for (int g = 0; g < 6; g++) send_group(1 + int'($urandom_range(3)), 0);
        end_stream();
        wait_drain();
        hold_mode = 1'b0;
    endtask

    task automatic test_start_clear();
        send_beat(0, 1'b0, 8'h11);
        send_beat(1, 1'b0, 8'h12);  // A large partial sum that start has to discard.
        end_stream();
        repeat (`CONV_LATENCY + 2) @(negedge aclk);
        write_reg(conv_cfg_pkg::CFG_CTRL, 8'h01);
        repeat (2) @(negedge aclk);
        send_group(2, 0);
        end_stream();
        wait_drain();
    endtask

    initial begin
        void'($urandom(32'h55a86561));
        aclken         = 1'b1;
        arst_n         = 1'b0;
        cfg_wr         = 1'b0;
        cfg_addr       = '0;
        cfg_wdata      = '0;
        s_valid        = 1'b0;
        s_weights_data = '0;
        s_pixels_data  = '0;
        s_last         = 1'b0;
        s_user         = '0;
        hold_mode      = 1'b0;
        groups_sent    = 0;
        repeat (5) @(negedge aclk);
        arst_n = 1'b1;
        @(negedge aclk);

        test_registers();
        test_single_beat();
        test_accumulate_saturate();
        test_taps_relu();
        test_enable_hold();
        test_start_clear();

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/conv_types_pkg.sv
design/conv_cfg_pkg.sv
design/conv_cfg_regs.sv
design/step_buffer.sv
design/conv_unit.sv
design/conv_core.sv
design/conv_engine.sv
bench/conv_engine_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the convolution engine testbench with Verilator and runs it.
# A failing check ends the run with $fatal, which gives a non-zero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module conv_engine_tb \
    -f sources.f

./obj_dir/Vconv_engine_tb
